/* Bender.yml */
package:
  name: wb_top

sources:
  - files:
      - wb_pkg.sv
      - wb_src_latch.sv
      - wb_arbiter.sv
      - rob_done_table.sv
      - wb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_wb_top.sv

/* rob_done_table.sv */
/* ROB completion table
   done, error and ecause per ROB id, written from the common bus */
`timescale 1ns/100ps

module rob_done_table (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,

  input  logic            wb_valid,
  input  logic            wb_error,
  input  wb_pkg::ecause_t wb_ecause,
  input  wb_pkg::robid_t  wb_robid,

  input  wb_pkg::robid_t  query_robid,
  output logic            query_done,
  output logic            query_error,
  output wb_pkg::ecause_t query_ecause
);
  import wb_pkg::*;

  logic [ROB_DEPTH-1:0] done_q;
  logic                 error_mem  [ROB_DEPTH];
  ecause_t              ecause_mem [ROB_DEPTH];

  // flush drops any same-cycle completion too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
    end else if (flush) begin
      done_q <= '0;
    end else if (wb_valid) begin
      done_q[wb_robid] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid) begin
      error_mem[wb_robid]  <= wb_error;
      ecause_mem[wb_robid] <= wb_ecause;
    end
  end

  // status only meaningful once the entry is done
  assign query_done   = done_q[query_robid];
  assign query_error  = done_q[query_robid] & error_mem[query_robid];
  assign query_ecause = done_q[query_robid] ? ecause_mem[query_robid] : ecause_t'(0);

endmodule

/* tb_wb_vectors.svh */
/* writeback stage test vectors
   one row per cycle of reports, with the bus, stall and query results one cycle later */
`ifndef TB_WB_VECTORS_SVH
`define TB_WB_VECTORS_SVH

// valid and stall masks use the source index as bit position, rename is bit 0
// columns: name, flush, valid, exp wb_valid, exp winner, exp stalls, exp query_done
task automatic load_vectors();
  add_vec("reset_idle",      1'b0, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b0);
  add_vec("single_rename",   1'b0, 7'b0000001, 1'b1, 0, 7'b0000000, 1'b0);
  add_vec("single_lsq",      1'b0, 7'b0000010, 1'b1, 1, 7'b0000000, 1'b1);
  add_vec("single_mcalu0",   1'b0, 7'b0000100, 1'b1, 2, 7'b0000000, 1'b1);
  add_vec("single_mcalu1",   1'b0, 7'b0001000, 1'b1, 3, 7'b0000000, 1'b1);
  add_vec("single_scalu0",   1'b0, 7'b0010000, 1'b1, 4, 7'b0000000, 1'b1);
  add_vec("single_scalu1",   1'b0, 7'b0100000, 1'b1, 5, 7'b0000000, 1'b1);
  add_vec("single_csr",      1'b0, 7'b1000000, 1'b1, 6, 7'b0000000, 1'b1);
  add_vec("single_idle",     1'b0, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b1);
  // rename against csr, then csr drains
  add_vec("prio_rename_csr", 1'b0, 7'b1000001, 1'b1, 0, 7'b1000000, 1'b1);
  add_vec("prio_csr_drains", 1'b0, 7'b0000000, 1'b1, 6, 7'b0000000, 1'b1);
  add_vec("prio_three",      1'b0, 7'b0110100, 1'b1, 2, 7'b0110000, 1'b1);
  add_vec("prio_three_b",    1'b0, 7'b0000000, 1'b1, 4, 7'b0100000, 1'b1);
  add_vec("prio_three_c",    1'b0, 7'b0000000, 1'b1, 5, 7'b0000000, 1'b1);
  // all six latched sources at once
  add_vec("drain_0",         1'b0, 7'b1111110, 1'b1, 1, 7'b1111100, 1'b1);
  add_vec("drain_1",         1'b0, 7'b0000000, 1'b1, 2, 7'b1111000, 1'b1);
  add_vec("drain_2",         1'b0, 7'b0000000, 1'b1, 3, 7'b1110000, 1'b1);
  add_vec("drain_3",         1'b0, 7'b0000000, 1'b1, 4, 7'b1100000, 1'b1);
  add_vec("drain_4",         1'b0, 7'b0000000, 1'b1, 5, 7'b1000000, 1'b1);
  add_vec("drain_5",         1'b0, 7'b0000000, 1'b1, 6, 7'b0000000, 1'b1);
  add_vec("drain_idle",      1'b0, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b1);
  // flush with everything pending
  add_vec("flush_setup",     1'b0, 7'b1111111, 1'b1, 0, 7'b1111110, 1'b1);
  add_vec("flush",           1'b1, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b0);
  add_vec("flush_idle",      1'b0, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b0);
  add_vec("post_flush_lsq",  1'b0, 7'b0000010, 1'b1, 1, 7'b0000000, 1'b0);
  add_vec("post_flush_idle", 1'b0, 7'b0000000, 1'b0, 0, 7'b0000000, 1'b1);
endtask

`endif

/* tb_wb_top.sv */
/* writeback stage testbench
   applies the vector table to the common data bus and checks bus, stalls and ROB table */
`timescale 1ns/100ps

module tb_wb_top;
  import wb_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_VECS     = 64;

  logic           clk;
  logic           rst_n;
  logic           rob_flush;

  logic           rename_valid;
  robid_t         rename_robid;
  preg_t          rename_rd;
  rename_result_t rename_result;

  logic    lsq_valid, mcalu0_valid, mcalu1_valid, scalu0_valid, scalu1_valid, csr_valid;
  logic    lsq_error, mcalu0_error, mcalu1_error, scalu0_error, scalu1_error, csr_error;
  ecause_t lsq_ecause, mcalu0_ecause, mcalu1_ecause, scalu0_ecause, scalu1_ecause, csr_ecause;
  robid_t  lsq_robid, mcalu0_robid, mcalu1_robid, scalu0_robid, scalu1_robid, csr_robid;
  preg_t   lsq_rd, mcalu0_rd, mcalu1_rd, scalu0_rd, scalu1_rd, csr_rd;
  xlen_t   lsq_result, mcalu0_result, mcalu1_result, scalu0_result, scalu1_result, csr_result;
  logic    lsq_stall, mcalu0_stall, mcalu1_stall, scalu0_stall, scalu1_stall, csr_stall;

  logic    wb_valid;
  logic    wb_error;
  ecause_t wb_ecause;
  robid_t  wb_robid;
  preg_t   wb_rd;
  xlen_t   wb_result;

  robid_t  query_robid;
  logic    query_done;
  logic    query_error;
  ecause_t query_ecause;

  // producer side state, indexed by source
  logic [SRC_COUNT-1:0]               cur_valid;
  logic [SRC_COUNT-1:0]               cur_error;
  logic [SRC_COUNT-1:0][ECAUSE_W-1:0] cur_ecause;
  logic [SRC_COUNT-1:0][ROBID_W-1:0]  cur_robid;
  logic [SRC_COUNT-1:0][PREG_W-1:0]   cur_rd;
  logic [SRC_COUNT-1:0][XLEN-1:0]     cur_result;
  logic [SRC_COUNT-1:0]               stall_vec;

  // last report expected on the bus, used for the query port
  robid_t  last_robid;
  logic    last_error;
  ecause_t last_ecause;
  logic    q_exp_error;
  ecause_t q_exp_ecause;

  string                vec_name      [MAX_VECS];
  logic                 vec_flush     [MAX_VECS];
  logic [SRC_COUNT-1:0] vec_valid     [MAX_VECS];
  logic                 vec_exp_valid [MAX_VECS];
  int                   vec_exp_src   [MAX_VECS];
  logic [SRC_COUNT-1:0] vec_exp_stall [MAX_VECS];
  logic                 vec_exp_qdone [MAX_VECS];
  int                   num_vecs = 0;

  integer seed = 37981;

  assign rename_valid  = cur_valid[SRC_RENAME];
  assign rename_robid  = cur_robid[SRC_RENAME];
  assign rename_rd     = cur_rd[SRC_RENAME];
  assign rename_result = cur_result[SRC_RENAME][RENAME_RESULT_W-1:0];

  assign {csr_valid, scalu1_valid, scalu0_valid, mcalu1_valid, mcalu0_valid, lsq_valid} =
    cur_valid[SRC_CSR:SRC_LSQ];
  assign {csr_error, scalu1_error, scalu0_error, mcalu1_error, mcalu0_error, lsq_error} =
    cur_error[SRC_CSR:SRC_LSQ];
  assign {csr_ecause, scalu1_ecause, scalu0_ecause, mcalu1_ecause, mcalu0_ecause,
          lsq_ecause} = cur_ecause[SRC_CSR:SRC_LSQ];
  assign {csr_robid, scalu1_robid, scalu0_robid, mcalu1_robid, mcalu0_robid, lsq_robid} =
    cur_robid[SRC_CSR:SRC_LSQ];
  assign {csr_rd, scalu1_rd, scalu0_rd, mcalu1_rd, mcalu0_rd, lsq_rd} =
    cur_rd[SRC_CSR:SRC_LSQ];
  assign {csr_result, scalu1_result, scalu0_result, mcalu1_result, mcalu0_result,
          lsq_result} = cur_result[SRC_CSR:SRC_LSQ];

  assign stall_vec = {csr_stall, scalu1_stall, scalu0_stall, mcalu1_stall, mcalu0_stall,
                      lsq_stall, 1'b0};

  wb_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic add_vec(input string name, input logic flush,
                         input logic [SRC_COUNT-1:0] valid, input logic exp_valid,
                         input int exp_src, input logic [SRC_COUNT-1:0] exp_stall,
                         input logic exp_qdone);
    vec_name[num_vecs]      = name;
    vec_flush[num_vecs]     = flush;
    vec_valid[num_vecs]     = valid;
    vec_exp_valid[num_vecs] = exp_valid;
    vec_exp_src[num_vecs]   = exp_src;
    vec_exp_stall[num_vecs] = exp_stall;
    vec_exp_qdone[num_vecs] = exp_qdone;
    num_vecs++;
  endtask

  `include "tb_wb_vectors.svh"

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test, field, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch in %s", test);
    end
  endtask

  task automatic drive_row(input int idx);
    logic [SRC_COUNT-1:0] held;
    held = stall_vec;
    rob_flush = vec_flush[idx];
    for (int s = 0; s < SRC_COUNT; s++) begin
      // stalled producer keeps its report
      if (!held[s]) begin
        cur_valid[s]  = vec_valid[idx][s];
        cur_error[s]  = $random(seed);
        cur_ecause[s] = $random(seed);
        cur_robid[s]  = $random(seed);
        cur_rd[s]     = $random(seed);
        cur_result[s] = $random(seed);
        // rename rd bit 5 set so the bus has to clear it
        if (s == SRC_RENAME) begin
          cur_rd[s][PREG_W-1] = 1'b1;
        end
      end
    end
    // a flush row keeps probing an entry that completed before it
    if (!vec_flush[idx]) begin
      query_robid  = last_robid;
      q_exp_error  = last_error;
      q_exp_ecause = last_ecause;
    end
  endtask

  task automatic check_row(input int idx);
    string   nm;
    int      w;
    logic    exp_error;
    ecause_t exp_ecause;
    robid_t  exp_robid;
    preg_t   exp_rd;
    xlen_t   exp_result;
    nm = vec_name[idx];
    w  = vec_exp_src[idx];
    check_value(nm, "wb_valid", 32'(vec_exp_valid[idx]), 32'(wb_valid));
    check_value(nm, "stall", 32'(vec_exp_stall[idx]), 32'(stall_vec));
    if (vec_exp_valid[idx]) begin
      exp_robid = cur_robid[w];
      if (w == SRC_RENAME) begin
        // rename is error free, rd bit 5 dropped, result word aligned
        exp_error  = 1'b0;
        exp_ecause = '0;
        exp_rd     = {1'b0, cur_rd[w][PREG_W-2:0]};
        exp_result = {cur_result[w][RENAME_RESULT_W-1:0], 2'b00};
      end else begin
        exp_error  = cur_error[w];
        exp_ecause = cur_ecause[w];
        exp_rd     = cur_rd[w];
        exp_result = cur_result[w];
      end
      check_value(nm, "wb_error", 32'(exp_error), 32'(wb_error));
      check_value(nm, "wb_ecause", 32'(exp_ecause), 32'(wb_ecause));
      check_value(nm, "wb_robid", 32'(exp_robid), 32'(wb_robid));
      check_value(nm, "wb_rd", 32'(exp_rd), 32'(wb_rd));
      check_value(nm, "wb_result", exp_result, wb_result);
    end
    check_value(nm, "query_done", 32'(vec_exp_qdone[idx]), 32'(query_done));
    if (vec_exp_qdone[idx]) begin
      check_value(nm, "query_error", 32'(q_exp_error), 32'(query_error));
      check_value(nm, "query_ecause", 32'(q_exp_ecause), 32'(query_ecause));
    end
    if (vec_exp_valid[idx]) begin
      last_robid  = exp_robid;
      last_error  = exp_error;
      last_ecause = exp_ecause;
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    rob_flush   = 1'b0;
    query_robid = '0;
    cur_valid   = '0;
    cur_error   = '0;
    cur_ecause  = '0;
    cur_robid   = '0;
    cur_rd      = '0;
    cur_result  = '0;
    last_robid  = $random(seed);
    last_error  = 1'b0;
    last_ecause = '0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    drive_row(0);
    // each row is checked one cycle after it was driven
    for (int i = 1; i < num_vecs; i++) begin
      @(negedge clk);
      check_row(i - 1);
      drive_row(i);
    end
    @(negedge clk);
    check_row(num_vecs - 1);
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    wait (num_vecs > 0);
    #(CLK_PERIOD * (num_vecs * 4 + RESET_CYCLES + 20));
    $display("simulation timed out before all vectors were applied");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

/* wb_arbiter.sv */
/* writeback arbiter
   fixed priority select of one report per cycle onto the common bus */
`timescale 1ns/100ps

module wb_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,

  // rename, never stalled
  input  logic                   rename_valid,
  input  wb_pkg::robid_t         rename_robid,
  input  wb_pkg::preg_t          rename_rd,
  input  wb_pkg::rename_result_t rename_result,

  input  logic                   lsq_valid,
  input  logic                   lsq_error,
  input  wb_pkg::ecause_t        lsq_ecause,
  input  wb_pkg::robid_t         lsq_robid,
  input  wb_pkg::preg_t          lsq_rd,
  input  wb_pkg::xlen_t          lsq_result,
  output logic                   lsq_stall,

  input  logic                   mcalu0_valid,
  input  logic                   mcalu0_error,
  input  wb_pkg::ecause_t        mcalu0_ecause,
  input  wb_pkg::robid_t         mcalu0_robid,
  input  wb_pkg::preg_t          mcalu0_rd,
  input  wb_pkg::xlen_t          mcalu0_result,
  output logic                   mcalu0_stall,

  input  logic                   mcalu1_valid,
  input  logic                   mcalu1_error,
  input  wb_pkg::ecause_t        mcalu1_ecause,
  input  wb_pkg::robid_t         mcalu1_robid,
  input  wb_pkg::preg_t          mcalu1_rd,
  input  wb_pkg::xlen_t          mcalu1_result,
  output logic                   mcalu1_stall,

  input  logic                   scalu0_valid,
  input  logic                   scalu0_error,
  input  wb_pkg::ecause_t        scalu0_ecause,
  input  wb_pkg::robid_t         scalu0_robid,
  input  wb_pkg::preg_t          scalu0_rd,
  input  wb_pkg::xlen_t          scalu0_result,
  output logic                   scalu0_stall,

  input  logic                   scalu1_valid,
  input  logic                   scalu1_error,
  input  wb_pkg::ecause_t        scalu1_ecause,
  input  wb_pkg::robid_t         scalu1_robid,
  input  wb_pkg::preg_t          scalu1_rd,
  input  wb_pkg::xlen_t          scalu1_result,
  output logic                   scalu1_stall,

  input  logic                   csr_valid,
  input  logic                   csr_error,
  input  wb_pkg::ecause_t        csr_ecause,
  input  wb_pkg::robid_t         csr_robid,
  input  wb_pkg::preg_t          csr_rd,
  input  wb_pkg::xlen_t          csr_result,
  output logic                   csr_stall,

  // common data bus
  output logic                   wb_valid,
  output logic                   wb_error,
  output wb_pkg::ecause_t        wb_ecause,
  output wb_pkg::robid_t         wb_robid,
  output wb_pkg::preg_t          wb_rd,
  output wb_pkg::xlen_t          wb_result
);
  import wb_pkg::*;

  logic                 rename_valid_q;
  robid_t               rename_robid_q;
  logic [PREG_W-2:0]    rename_rd_q;
  rename_result_t       rename_result_q;

  logic [SRC_COUNT-1:0] src_valid;
  logic [SRC_COUNT-1:0] src_grant;
  logic                 src_error  [SRC_COUNT];
  ecause_t              src_ecause [SRC_COUNT];
  robid_t               src_robid  [SRC_COUNT];
  preg_t                src_rd     [SRC_COUNT];
  xlen_t                src_result [SRC_COUNT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rename_valid_q <= 1'b0;
    end else if (flush) begin
      rename_valid_q <= 1'b0;
    end else begin
      rename_valid_q <= rename_valid;
    end
  end

  // rd bit 5 never reaches the bus from rename
  always_ff @(posedge clk) begin
    rename_robid_q  <= rename_robid;
    rename_rd_q     <= rename_rd[PREG_W-2:0];
    rename_result_q <= rename_result;
  end

  assign src_valid[SRC_RENAME] = rename_valid_q;
  assign src_valid[SRC_LSQ]    = lsq_valid;
  assign src_valid[SRC_MCALU0] = mcalu0_valid;
  assign src_valid[SRC_MCALU1] = mcalu1_valid;
  assign src_valid[SRC_SCALU0] = scalu0_valid;
  assign src_valid[SRC_SCALU1] = scalu1_valid;
  assign src_valid[SRC_CSR]    = csr_valid;

  assign src_error = '{SRC_RENAME: 1'b0, SRC_LSQ: lsq_error,
                       SRC_MCALU0: mcalu0_error, SRC_MCALU1: mcalu1_error,
                       SRC_SCALU0: scalu0_error, SRC_SCALU1: scalu1_error,
                       SRC_CSR: csr_error};
  assign src_ecause = '{SRC_RENAME: ecause_t'(0), SRC_LSQ: lsq_ecause,
                        SRC_MCALU0: mcalu0_ecause, SRC_MCALU1: mcalu1_ecause,
                        SRC_SCALU0: scalu0_ecause, SRC_SCALU1: scalu1_ecause,
                        SRC_CSR: csr_ecause};
  assign src_robid = '{SRC_RENAME: rename_robid_q, SRC_LSQ: lsq_robid,
                       SRC_MCALU0: mcalu0_robid, SRC_MCALU1: mcalu1_robid,
                       SRC_SCALU0: scalu0_robid, SRC_SCALU1: scalu1_robid,
                       SRC_CSR: csr_robid};
  assign src_rd = '{SRC_RENAME: {1'b0, rename_rd_q}, SRC_LSQ: lsq_rd,
                    SRC_MCALU0: mcalu0_rd, SRC_MCALU1: mcalu1_rd,
                    SRC_SCALU0: scalu0_rd, SRC_SCALU1: scalu1_rd,
                    SRC_CSR: csr_rd};
  assign src_result = '{SRC_RENAME: {rename_result_q, 2'b00}, SRC_LSQ: lsq_result,
                        SRC_MCALU0: mcalu0_result, SRC_MCALU1: mcalu1_result,
                        SRC_SCALU0: scalu0_result, SRC_SCALU1: scalu1_result,
                        SRC_CSR: csr_result};

  // isolate lowest set bit
  assign src_grant = src_valid & (~src_valid + 1'b1);

  always_comb begin
    wb_error  = 1'b0;
    wb_ecause = '0;
    wb_robid  = '0;
    wb_rd     = '0;
    wb_result = '0;
    for (int i = 0; i < SRC_COUNT; i++) begin
      if (src_grant[i]) begin
        wb_error  = src_error[i];
        wb_ecause = src_ecause[i];
        wb_robid  = src_robid[i];
        wb_rd     = src_rd[i];
        wb_result = src_result[i];
      end
    end
  end

  assign wb_valid = |src_valid;

  // losers hold their latch
  assign lsq_stall    = src_valid[SRC_LSQ]    & ~src_grant[SRC_LSQ];
  assign mcalu0_stall = src_valid[SRC_MCALU0] & ~src_grant[SRC_MCALU0];
  assign mcalu1_stall = src_valid[SRC_MCALU1] & ~src_grant[SRC_MCALU1];
  assign scalu0_stall = src_valid[SRC_SCALU0] & ~src_grant[SRC_SCALU0];
  assign scalu1_stall = src_valid[SRC_SCALU1] & ~src_grant[SRC_SCALU1];
  assign csr_stall    = src_valid[SRC_CSR]    & ~src_grant[SRC_CSR];

endmodule

/* wb_pkg.sv */
/* writeback package
   widths, source priorities and ROB depth shared by the common data bus */
package wb_pkg;

  localparam int ROBID_W  = 7;
  localparam int PREG_W   = 6;
  localparam int ECAUSE_W = 5;
  localparam int XLEN     = 32;

  // rename result drops the two low bits, always word aligned
  localparam int RENAME_RESULT_W = XLEN - 2;

  localparam int ROB_DEPTH = 1 << ROBID_W;

  // index doubles as priority, lowest wins
  localparam int SRC_COUNT  = 7;
  localparam int SRC_RENAME = 0;
  localparam int SRC_LSQ    = 1;
  localparam int SRC_MCALU0 = 2;
  localparam int SRC_MCALU1 = 3;
  localparam int SRC_SCALU0 = 4;
  localparam int SRC_SCALU1 = 5;
  localparam int SRC_CSR    = 6;

  typedef logic [ROBID_W-1:0]         robid_t;
  typedef logic [PREG_W-1:0]          preg_t;
  typedef logic [ECAUSE_W-1:0]        ecause_t;
  typedef logic [XLEN-1:0]            xlen_t;
  typedef logic [RENAME_RESULT_W-1:0] rename_result_t;

endpackage

/* wb_src_latch.sv */
/* writeback source latch
   holds one execution unit report until the arbiter lets it go */
`timescale 1ns/100ps

module wb_src_latch (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            stall,

  input  logic            valid,
  input  logic            error,
  input  wb_pkg::ecause_t ecause,
  input  wb_pkg::robid_t  robid,
  input  wb_pkg::preg_t   rd,
  input  wb_pkg::xlen_t   result,

  output logic            q_valid,
  output logic            q_error,
  output wb_pkg::ecause_t q_ecause,
  output wb_pkg::robid_t  q_robid,
  output wb_pkg::preg_t   q_rd,
  output wb_pkg::xlen_t   q_result
);
  import wb_pkg::*;

  // flush beats a held report
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_valid <= 1'b0;
    end else if (flush) begin
      q_valid <= 1'b0;
    end else if (!stall) begin
      q_valid <= valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      q_error  <= error;
      q_ecause <= ecause;
      q_robid  <= robid;
      q_rd     <= rd;
      q_result <= result;
    end
  end

endmodule

/* wb_top.f */
+incdir+.
wb_pkg.sv
wb_src_latch.sv
wb_arbiter.sv
rob_done_table.sv
wb_top.sv
tb_wb_top.sv

/* wb_top.sv */
/* writeback stage top
   source latches, arbiter and ROB completion table */
`timescale 1ns/100ps

module wb_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rob_flush,

  input  logic                   rename_valid,
  input  wb_pkg::robid_t         rename_robid,
  input  wb_pkg::preg_t          rename_rd,
  input  wb_pkg::rename_result_t rename_result,

  input  logic                   lsq_valid,
  input  logic                   lsq_error,
  input  wb_pkg::ecause_t        lsq_ecause,
  input  wb_pkg::robid_t         lsq_robid,
  input  wb_pkg::preg_t          lsq_rd,
  input  wb_pkg::xlen_t          lsq_result,
  output logic                   lsq_stall,

  input  logic                   mcalu0_valid,
  input  logic                   mcalu0_error,
  input  wb_pkg::ecause_t        mcalu0_ecause,
  input  wb_pkg::robid_t         mcalu0_robid,
  input  wb_pkg::preg_t          mcalu0_rd,
  input  wb_pkg::xlen_t          mcalu0_result,
  output logic                   mcalu0_stall,

  input  logic                   mcalu1_valid,
  input  logic                   mcalu1_error,
  input  wb_pkg::ecause_t        mcalu1_ecause,
  input  wb_pkg::robid_t         mcalu1_robid,
  input  wb_pkg::preg_t          mcalu1_rd,
  input  wb_pkg::xlen_t          mcalu1_result,
  output logic                   mcalu1_stall,

  input  logic                   scalu0_valid,
  input  logic                   scalu0_error,
  input  wb_pkg::ecause_t        scalu0_ecause,
  input  wb_pkg::robid_t         scalu0_robid,
  input  wb_pkg::preg_t          scalu0_rd,
  input  wb_pkg::xlen_t          scalu0_result,
  output logic                   scalu0_stall,

  input  logic                   scalu1_valid,
  input  logic                   scalu1_error,
  input  wb_pkg::ecause_t        scalu1_ecause,
  input  wb_pkg::robid_t         scalu1_robid,
  input  wb_pkg::preg_t          scalu1_rd,
  input  wb_pkg::xlen_t          scalu1_result,
  output logic                   scalu1_stall,

  input  logic                   csr_valid,
  input  logic                   csr_error,
  input  wb_pkg::ecause_t        csr_ecause,
  input  wb_pkg::robid_t         csr_robid,
  input  wb_pkg::preg_t          csr_rd,
  input  wb_pkg::xlen_t          csr_result,
  output logic                   csr_stall,

  output logic                   wb_valid,
  output logic                   wb_error,
  output wb_pkg::ecause_t        wb_ecause,
  output wb_pkg::robid_t         wb_robid,
  output wb_pkg::preg_t          wb_rd,
  output wb_pkg::xlen_t          wb_result,

  input  wb_pkg::robid_t         query_robid,
  output logic                   query_done,
  output logic                   query_error,
  output wb_pkg::ecause_t        query_ecause
);
  import wb_pkg::*;

  // latched reports
  logic    lsq_q_valid, mcalu0_q_valid, mcalu1_q_valid;
  logic    scalu0_q_valid, scalu1_q_valid, csr_q_valid;
  logic    lsq_q_error, mcalu0_q_error, mcalu1_q_error;
  logic    scalu0_q_error, scalu1_q_error, csr_q_error;
  ecause_t lsq_q_ecause, mcalu0_q_ecause, mcalu1_q_ecause;
  ecause_t scalu0_q_ecause, scalu1_q_ecause, csr_q_ecause;
  robid_t  lsq_q_robid, mcalu0_q_robid, mcalu1_q_robid;
  robid_t  scalu0_q_robid, scalu1_q_robid, csr_q_robid;
  preg_t   lsq_q_rd, mcalu0_q_rd, mcalu1_q_rd;
  preg_t   scalu0_q_rd, scalu1_q_rd, csr_q_rd;
  xlen_t   lsq_q_result, mcalu0_q_result, mcalu1_q_result;
  xlen_t   scalu0_q_result, scalu1_q_result, csr_q_result;

  wb_src_latch u_lsq_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(lsq_stall),
    .valid(lsq_valid), .error(lsq_error), .ecause(lsq_ecause),
    .robid(lsq_robid), .rd(lsq_rd), .result(lsq_result),
    .q_valid(lsq_q_valid), .q_error(lsq_q_error), .q_ecause(lsq_q_ecause),
    .q_robid(lsq_q_robid), .q_rd(lsq_q_rd), .q_result(lsq_q_result)
  );

  wb_src_latch u_mcalu0_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(mcalu0_stall),
    .valid(mcalu0_valid), .error(mcalu0_error), .ecause(mcalu0_ecause),
    .robid(mcalu0_robid), .rd(mcalu0_rd), .result(mcalu0_result),
    .q_valid(mcalu0_q_valid), .q_error(mcalu0_q_error), .q_ecause(mcalu0_q_ecause),
    .q_robid(mcalu0_q_robid), .q_rd(mcalu0_q_rd), .q_result(mcalu0_q_result)
  );

  wb_src_latch u_mcalu1_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(mcalu1_stall),
    .valid(mcalu1_valid), .error(mcalu1_error), .ecause(mcalu1_ecause),
    .robid(mcalu1_robid), .rd(mcalu1_rd), .result(mcalu1_result),
    .q_valid(mcalu1_q_valid), .q_error(mcalu1_q_error), .q_ecause(mcalu1_q_ecause),
    .q_robid(mcalu1_q_robid), .q_rd(mcalu1_q_rd), .q_result(mcalu1_q_result)
  );

  wb_src_latch u_scalu0_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(scalu0_stall),
    .valid(scalu0_valid), .error(scalu0_error), .ecause(scalu0_ecause),
    .robid(scalu0_robid), .rd(scalu0_rd), .result(scalu0_result),
    .q_valid(scalu0_q_valid), .q_error(scalu0_q_error), .q_ecause(scalu0_q_ecause),
    .q_robid(scalu0_q_robid), .q_rd(scalu0_q_rd), .q_result(scalu0_q_result)
  );

  wb_src_latch u_scalu1_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(scalu1_stall),
    .valid(scalu1_valid), .error(scalu1_error), .ecause(scalu1_ecause),
    .robid(scalu1_robid), .rd(scalu1_rd), .result(scalu1_result),
    .q_valid(scalu1_q_valid), .q_error(scalu1_q_error), .q_ecause(scalu1_q_ecause),
    .q_robid(scalu1_q_robid), .q_rd(scalu1_q_rd), .q_result(scalu1_q_result)
  );

  // csr has its own latch at the lowest priority
  wb_src_latch u_csr_latch (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush), .stall(csr_stall),
    .valid(csr_valid), .error(csr_error), .ecause(csr_ecause),
    .robid(csr_robid), .rd(csr_rd), .result(csr_result),
    .q_valid(csr_q_valid), .q_error(csr_q_error), .q_ecause(csr_q_ecause),
    .q_robid(csr_q_robid), .q_rd(csr_q_rd), .q_result(csr_q_result)
  );

  wb_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush),
    .rename_valid(rename_valid), .rename_robid(rename_robid),
    .rename_rd(rename_rd), .rename_result(rename_result),
    .lsq_valid(lsq_q_valid), .lsq_error(lsq_q_error), .lsq_ecause(lsq_q_ecause),
    .lsq_robid(lsq_q_robid), .lsq_rd(lsq_q_rd), .lsq_result(lsq_q_result),
    .lsq_stall(lsq_stall),
    .mcalu0_valid(mcalu0_q_valid), .mcalu0_error(mcalu0_q_error),
    .mcalu0_ecause(mcalu0_q_ecause), .mcalu0_robid(mcalu0_q_robid),
    .mcalu0_rd(mcalu0_q_rd), .mcalu0_result(mcalu0_q_result),
    .mcalu0_stall(mcalu0_stall),
    .mcalu1_valid(mcalu1_q_valid), .mcalu1_error(mcalu1_q_error),
    .mcalu1_ecause(mcalu1_q_ecause), .mcalu1_robid(mcalu1_q_robid),
    .mcalu1_rd(mcalu1_q_rd), .mcalu1_result(mcalu1_q_result),
    .mcalu1_stall(mcalu1_stall),
    .scalu0_valid(scalu0_q_valid), .scalu0_error(scalu0_q_error),
    .scalu0_ecause(scalu0_q_ecause), .scalu0_robid(scalu0_q_robid),
    .scalu0_rd(scalu0_q_rd), .scalu0_result(scalu0_q_result),
    .scalu0_stall(scalu0_stall),
    .scalu1_valid(scalu1_q_valid), .scalu1_error(scalu1_q_error),
    .scalu1_ecause(scalu1_q_ecause), .scalu1_robid(scalu1_q_robid),
    .scalu1_rd(scalu1_q_rd), .scalu1_result(scalu1_q_result),
    .scalu1_stall(scalu1_stall),
    .csr_valid(csr_q_valid), .csr_error(csr_q_error), .csr_ecause(csr_q_ecause),
    .csr_robid(csr_q_robid), .csr_rd(csr_q_rd), .csr_result(csr_q_result),
    .csr_stall(csr_stall),
    .wb_valid(wb_valid), .wb_error(wb_error), .wb_ecause(wb_ecause),
    .wb_robid(wb_robid), .wb_rd(wb_rd), .wb_result(wb_result)
  );

  rob_done_table u_done_table (
    .clk(clk), .rst_n(rst_n), .flush(rob_flush),
    .wb_valid(wb_valid), .wb_error(wb_error), .wb_ecause(wb_ecause),
    .wb_robid(wb_robid),
    .query_robid(query_robid), .query_done(query_done),
    .query_error(query_error), .query_ecause(query_ecause)
  );

endmodule
